//--- hdl/spi_proto_pkg.sv
`default_nettype none

package spi_proto_pkg;

    // command byte layout
    localparam int CMD_WE_BIT      = 7;
    localparam int CMD_TARGET_LSB  = 4;
    localparam int CMD_ADDR_HIGH_W = 4;

    typedef enum logic [1:0] {
        TARGET_CSR  = 2'b00,
        TARGET_PROM = 2'b10
    } cmd_target_t;

    // fixed bytes shifted back while the header is received
    localparam logic [7:0] REPLY_CMD       = 8'hCC;
    localparam logic [7:0] REPLY_CSR_ADDR  = 8'hAD;
    localparam logic [7:0] REPLY_PROM_MID  = 8'hA0;
    localparam logic [7:0] REPLY_PROM_LOW  = 8'hA1;
    localparam logic [7:0] REPLY_PROM_DATA = 8'hDD;

    typedef enum logic [2:0] {
        IDLE,
        CSR_ADDR,
        CSR_DATA,
        CSR_RESPOND,
        PROM_MID,
        PROM_LOW,
        PROM_DATA
    } bridge_state_t;

    typedef struct packed {
        logic [11:0] addr;
        logic [7:0]  unused;
    } csr_view_t;

    // one address register, seen as a register address or a word address
    typedef union packed {
        csr_view_t   csr_view;
        logic [19:0] prom_view;
    } bridge_addr_u;

endpackage

`default_nettype wire

//--- hdl/csr_map_pkg.sv
`default_nettype none

package csr_map_pkg;

    localparam int NUM_CH       = 8;
    localparam int NUM_SPDIF_IN = 3;
    localparam int NUM_RATE     = 5;

    localparam int CSR_ADDR_W = 12;

    // flattened bus widths
    localparam int VOL_W  = NUM_CH * 32;
    localparam int RATE_W = NUM_SPDIF_IN * NUM_RATE;

    // volume block, four bytes per channel, byte 0 is bits 7:0
    localparam logic [CSR_ADDR_W-1:0] VOL_BASE  = 12'h000;
    localparam int                    VOL_SPAN  = NUM_CH * 4;
    localparam int                    VOL_OFF_W = $clog2(VOL_SPAN);

    // rate block, one byte per input
    localparam logic [CSR_ADDR_W-1:0] RATE_BASE  = 12'h100;
    localparam int                    RATE_OFF_W = $clog2(NUM_SPDIF_IN);

endpackage

`default_nettype wire

//--- hdl/spi_trx.sv
`default_nettype none

module spi_trx (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       sck_i,
    input  logic       mosi_i,
    input  logic       ss_n_i,
    output logic       miso_o,
    output logic [7:0] rx_data_o,
    output logic       rx_valid_o,
    input  logic [7:0] tx_data_i,
    input  logic       tx_load_i,
    output logic       frame_end_o
);

    // two sync stages, the third flop is only for edge detection
    logic [2:0] sck_sr;
    logic [2:0] ss_sr;
    logic [1:0] mosi_sr;
    logic       sck_rise;
    logic       sck_fall;
    logic       ss_n_s;
    logic [2:0] bit_cnt;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;
    logic [7:0] tx_pending;

    assign sck_rise    = sck_sr[1] & ~sck_sr[2];
    assign sck_fall    = ~sck_sr[1] & sck_sr[2];
    assign ss_n_s      = ss_sr[1];
    assign frame_end_o = ss_sr[1] & ~ss_sr[2];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sck_sr     <= 3'b000;
            ss_sr      <= 3'b111;
            bit_cnt    <= 3'd0;
            rx_valid_o <= 1'b0;
        end else begin
            sck_sr     <= {sck_sr[1:0], sck_i};
            ss_sr      <= {ss_sr[1:0], ss_n_i};
            rx_valid_o <= 1'b0;
            if (ss_n_s) begin
                bit_cnt <= 3'd0;
            end else if (sck_rise) begin
                bit_cnt    <= bit_cnt + 3'd1;
                rx_valid_o <= (bit_cnt == 3'd7);
            end
        end
    end

    // mosi goes through the same depth as sck, so both line up
    always_ff @(posedge clk) begin
        mosi_sr <= {mosi_sr[0], mosi_i};
        if (sck_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_sr[1]};
        end
    end

    assign rx_data_o = rx_shift;

    // falling edge after the last bit starts the next byte out of tx_pending
    always_ff @(posedge clk) begin
        if (ss_n_s) begin
            tx_shift   <= 8'h00;
            tx_pending <= 8'h00;
        end else begin
            if (sck_fall) begin
                if (bit_cnt == 3'd0) begin
                    tx_shift   <= tx_pending;
                    tx_pending <= 8'h00;
                end else begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
            if (tx_load_i) begin
                tx_pending <= tx_data_i;
            end
        end
    end

    assign miso_o = tx_shift[7];

endmodule

`default_nettype wire

//--- hdl/csr_regs.sv
`default_nettype none

module csr_regs (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic [csr_map_pkg::CSR_ADDR_W-1:0] csr_addr_i,
    input  logic                               wr_i,
    input  logic [7:0]                         wr_data_i,
    output logic [7:0]                         rd_data_o,
    output logic [csr_map_pkg::VOL_W-1:0]      vol_o,
    input  logic [csr_map_pkg::RATE_W-1:0]     rate_i
);

    import csr_map_pkg::*;

    logic [CSR_ADDR_W-1:0] vol_off;
    logic [CSR_ADDR_W-1:0] rate_off;
    logic                  vol_hit;
    logic                  rate_hit;
    logic [NUM_RATE-1:0]   rate_sel;

    assign vol_off  = csr_addr_i - VOL_BASE;
    assign rate_off = csr_addr_i - RATE_BASE;

    // addresses below a base wrap to large offsets, one compare per block
    assign vol_hit  = vol_off < VOL_SPAN;
    assign rate_hit = rate_off < NUM_SPDIF_IN;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            vol_o <= '0;
        end else if (wr_i && vol_hit) begin
            vol_o[{vol_off[VOL_OFF_W-1:0], 3'b000} +: 8] <= wr_data_i;
        end
    end

    always_comb begin
        rate_sel  = '0;
        rd_data_o = 8'h00;
        if (vol_hit) begin
            rd_data_o = vol_o[{vol_off[VOL_OFF_W-1:0], 3'b000} +: 8];
        end else if (rate_hit) begin
            rate_sel  = rate_i[rate_off[RATE_OFF_W-1:0] * NUM_RATE +: NUM_RATE];
            rd_data_o = {{(8 - NUM_RATE){1'b0}}, rate_sel};
        end
    end

endmodule

`default_nettype wire

//--- hdl/csr_spi.sv
`default_nettype none

module csr_spi (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           sck_i,
    input  logic                           mosi_i,
    input  logic                           ss_n_i,
    output logic                           miso_o,
    output logic [csr_map_pkg::VOL_W-1:0]  vol_o,
    input  logic [csr_map_pkg::RATE_W-1:0] rate_i,
    output logic [31:0]                    prom_addr_o,
    output logic [31:0]                    prom_data_o,
    output logic                           prom_ack_o
);

    import spi_proto_pkg::*;
    import csr_map_pkg::*;

    logic [7:0]            rx_data;
    logic                  rx_valid;
    logic [7:0]            tx_data_q;
    logic                  tx_load_q;
    logic                  frame_end;

    bridge_state_t         state_q;
    bridge_addr_u          addr_q;
    cmd_target_t           cmd_target;
    logic                  cmd_we_q;
    logic                  cmd_seen_q;
    logic [1:0]            offset_q;
    logic [23:0]           wdata_q;
    logic                  prom_byte;

    logic [CSR_ADDR_W-1:0] csr_addr;
    logic                  csr_wr;
    logic [7:0]            csr_rd_data;

    spi_trx spi_trx_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .sck_i       (sck_i),
        .mosi_i      (mosi_i),
        .ss_n_i      (ss_n_i),
        .miso_o      (miso_o),
        .rx_data_o   (rx_data),
        .rx_valid_o  (rx_valid),
        .tx_data_i   (tx_data_q),
        .tx_load_i   (tx_load_q),
        .frame_end_o (frame_end)
    );

    assign cmd_target = cmd_target_t'(rx_data[CMD_TARGET_LSB +: 2]);
    assign csr_addr   = addr_q.csr_view.addr;
    assign csr_wr     = (state_q == CSR_DATA) && rx_valid && cmd_we_q;
    assign prom_byte  = (state_q == PROM_DATA) && rx_valid;

    csr_regs csr_regs_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .csr_addr_i (csr_addr),
        .wr_i       (csr_wr),
        .wr_data_i  (rx_data),
        .rd_data_o  (csr_rd_data),
        .vol_o      (vol_o),
        .rate_i     (rate_i)
    );

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            addr_q     <= '0;
            cmd_we_q   <= 1'b0;
            cmd_seen_q <= 1'b0;
            offset_q   <= 2'd0;
            tx_data_q  <= 8'h00;
            tx_load_q  <= 1'b0;
            prom_ack_o <= 1'b0;
        end else begin
            tx_load_q  <= 1'b0;
            prom_ack_o <= prom_byte && cmd_we_q && (offset_q == 2'd3);
            // next word address once the finished word has been acked
            if (prom_ack_o) begin
                addr_q.prom_view <= addr_q.prom_view + 20'd1;
            end
            if (frame_end) begin
                state_q    <= IDLE;
                cmd_seen_q <= 1'b0;
                offset_q   <= 2'd0;
            end else begin
                case (state_q)
                    IDLE: begin
                        // only the first byte of a frame is a command
                        if (rx_valid && !cmd_seen_q) begin
                            cmd_seen_q       <= 1'b1;
                            cmd_we_q         <= rx_data[CMD_WE_BIT];
                            addr_q.prom_view <= {rx_data[CMD_ADDR_HIGH_W-1:0], 16'h0000};
                            tx_data_q        <= REPLY_CMD;
                            tx_load_q        <= 1'b1;
                            case (cmd_target)
                                TARGET_CSR:  state_q <= CSR_ADDR;
                                TARGET_PROM: state_q <= PROM_MID;
                                default:     state_q <= IDLE;
                            endcase
                        end
                    end
                    CSR_ADDR: begin
                        if (rx_valid) begin
                            addr_q.csr_view.addr[7:0] <= rx_data;
                            tx_data_q                 <= REPLY_CSR_ADDR;
                            tx_load_q                 <= 1'b1;
                            state_q                   <= CSR_DATA;
                        end
                    end
                    CSR_DATA: begin
                        if (rx_valid) begin
                            state_q <= CSR_RESPOND;
                        end
                    end
                    CSR_RESPOND: begin
                        // reply is taken from the address before the increment
                        tx_data_q            <= csr_rd_data;
                        tx_load_q            <= 1'b1;
                        addr_q.csr_view.addr <= addr_q.csr_view.addr + 12'd1;
                        state_q              <= CSR_DATA;
                    end
                    PROM_MID: begin
                        if (rx_valid) begin
                            addr_q.prom_view[15:8] <= rx_data;
                            tx_data_q              <= REPLY_PROM_MID;
                            tx_load_q              <= 1'b1;
                            state_q                <= PROM_LOW;
                        end
                    end
                    PROM_LOW: begin
                        if (rx_valid) begin
                            addr_q.prom_view[7:0] <= rx_data;
                            tx_data_q             <= REPLY_PROM_LOW;
                            tx_load_q             <= 1'b1;
                            state_q               <= PROM_DATA;
                        end
                    end
                    PROM_DATA: begin
                        if (rx_valid) begin
                            tx_data_q <= REPLY_PROM_DATA;
                            tx_load_q <= 1'b1;
                            offset_q  <= offset_q + 2'd1;
                        end
                    end
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

    // little-endian word assembly, the fourth byte completes the word
    always_ff @(posedge clk) begin
        if (prom_byte && cmd_we_q) begin
            if (offset_q == 2'd3) begin
                prom_data_o <= {rx_data, wdata_q};
                prom_addr_o <= {12'h000, addr_q.prom_view};
            end else begin
                wdata_q[{offset_q, 3'b000} +: 8] <= rx_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/csr_spi_assertions.sv
`default_nettype none

module csr_spi_assertions (
    input logic                          clk,
    input logic                          rst_n_i,
    input logic                          ss_n_i,
    input logic                          miso_i,
    input logic                          prom_ack_i,
    input logic                          wr_i,
    input logic [csr_map_pkg::VOL_W-1:0] vol_i
);

    ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        prom_ack_i |=> !prom_ack_i)
        else $error("prom_ack_o was high for two cycles in a row");

    // the host samples miso for the whole frame
    miso_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        !ss_n_i |-> !$isunknown(miso_i))
        else $error("miso_o is unknown while ss_n_i is low");

    vol_on_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        (vol_i != $past(vol_i)) |-> $past(wr_i))
        else $error("vol_o changed without a register write");

endmodule

bind csr_spi csr_spi_assertions csr_spi_assertions_i (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .ss_n_i     (ss_n_i),
    .miso_i     (miso_o),
    .prom_ack_i (prom_ack_o),
    .wr_i       (csr_wr),
    .vol_i      (vol_o)
);

`default_nettype wire

//--- sim/csr_spi_tb.sv
`default_nettype none

module csr_spi_tb;

    import csr_map_pkg::*;

    localparam int SCK_HALF = 4;

    logic              clk;
    logic              rst_n_i;
    logic              sck_i;
    logic              mosi_i;
    logic              ss_n_i;
    logic              miso_o;
    logic [VOL_W-1:0]  vol_o;
    logic [RATE_W-1:0] rate_i;
    logic [31:0]       prom_addr_o;
    logic [31:0]       prom_data_o;
    logic              prom_ack_o;

    // parsed stimulus kinds and their fields in file order
    logic [7:0]  kind_q[$];
    logic [31:0] field_q[$];
    logic [31:0] exp_addr_q[$];
    logic [31:0] exp_data_q[$];
    logic [7:0]  mosi_buf[32];
    logic [7:0]  exp_buf[32];
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    csr_spi csr_spi_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_vol(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_prom(input string name, input logic [31:0] exp_addr,
                              input logic [31:0] exp_data, input logic [31:0] act_addr,
                              input logic [31:0] act_data);
        if (act_addr !== exp_addr || act_data !== exp_data) begin
            stop_with_error($sformatf("Fail %s: expected %h/%h, actual %h/%h",
                                      name, exp_addr, exp_data, act_addr, act_data));
        end
    endtask

    task automatic read_stimulus(output int total);
        int               fd;
        int               code;
        int               n;
        logic [7:0]       kind;
        logic [31:0]      val;
        logic [8*160-1:0] line;
        total = 0;
        fd = $fopen("sim/csr_spi_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_error("could not open the stimulus file");
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                code = $fgets(line, fd);
            end else begin
                kind_q.push_back(kind);
                n = (kind == "R") ? 1 : 2;
                // a transaction carries its byte count and then mosi/miso pairs
                if (kind == "T") begin
                    code = $fscanf(fd, "%d", val);
                    field_q.push_back(val);
                    total += val;
                    n = 2 * val;
                end
                repeat (n) begin
                    code = $fscanf(fd, "%h", val);
                    field_q.push_back(val);
                end
            end
        end
        $fclose(fd);
    endtask

    // SPI mode 0 host that samples miso just before each rising sck
    task automatic run_transaction(input int idx);
        int          n;
        int          k;
        int          b;
        logic [31:0] m;
        logic [7:0]  rx;
        n = field_q.pop_front();
        for (k = 0; k < n; k++) begin
            m = field_q.pop_front();
            mosi_buf[k] = m[8] ? 8'($urandom()) : m[7:0];
            exp_buf[k] = 8'(field_q.pop_front());
        end
        @(negedge clk);
        ss_n_i = 1'b0;
        repeat (SCK_HALF) @(negedge clk);
        for (k = 0; k < n; k++) begin
            for (b = 7; b >= 0; b--) begin
                mosi_i = mosi_buf[k][b];
                repeat (SCK_HALF) @(negedge clk);
                rx[b] = miso_o;
                sck_i = 1'b1;
                repeat (SCK_HALF) @(negedge clk);
                sck_i = 1'b0;
            end
            check_byte($sformatf("transaction %0d byte %0d", idx, k), exp_buf[k], rx);
        end
        repeat (SCK_HALF) @(negedge clk);
        ss_n_i = 1'b1;
        repeat (2 * SCK_HALF) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            stop_with_error("timeout, the stimulus did not complete within the cycle limit");
        end
    end

    // every word strobe must match the oldest expected word
    always @(negedge clk) begin
        if (rst_n_i && prom_ack_o) begin
            if (exp_addr_q.size() == 0) begin
                stop_with_error("a program memory word was written when none was expected");
            end else begin
                check_prom("program memory word", exp_addr_q.pop_front(),
                           exp_data_q.pop_front(), prom_addr_o, prom_data_o);
            end
        end
    end

    initial begin
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] d;
        int          total;
        int          t_idx;
        rst_n_i = 1'b0;
        sck_i   = 1'b0;
        mosi_i  = 1'b0;
        ss_n_i  = 1'b1;
        rate_i  = '0;
        t_idx   = 0;
        void'($urandom(60));
        read_stimulus(total);
        cycle_limit = total * 80 + 200;
        repeat (4) @(negedge clk);
        rst_n_i = 1'b1;
        while (kind_q.size() > 0) begin
            kind = kind_q.pop_front();
            if (kind == "T") begin
                run_transaction(t_idx);
                t_idx++;
            end else if (kind == "V") begin
                a = field_q.pop_front();
                d = field_q.pop_front();
                check_vol($sformatf("volume of channel %0d", a), d, vol_o[a*32 +: 32]);
            end else if (kind == "P") begin
                exp_addr_q.push_back(field_q.pop_front());
                exp_data_q.push_back(field_q.pop_front());
            end else if (kind == "R") begin
                a = field_q.pop_front();
                @(negedge clk);
                rate_i = a[RATE_W-1:0];
            end else begin
                stop_with_error($sformatf("unknown line kind %c in the stimulus file", kind));
            end
        end
        if (exp_addr_q.size() != 0) begin
            stop_with_error("expected program memory words were never written");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/csr_spi_stimulus.txt
# T: byte count (decimal), then a mosi byte and the expected miso byte for each (mosi 100 = filler)
# V: channel and expected volume. P: expected prom address and data. R: value driven on rate_i
R 7CB1
T 6 80 00 0C CC 11 AD 22 11 33 22 44 33
V 3 44332211
V 2 00000000
V 4 00000000
T 4 80 00 1E CC AA AD BB AA
V 7 BBAA0000
V 3 44332211
# reads of volumes, rates and unmapped addresses
T 7 00 00 0C CC 100 AD 100 11 100 22 100 33 100 44
T 7 01 00 00 CC 100 AD 100 11 100 05 100 1F 100 00
T 6 00 00 FE CC 100 AD 100 00 100 00 100 11
T 4 80 00 20 CC 5A AD 100 00
# program memory, two words from 0x23456
P 00023456 04030201
P 00023457 08070605
T 11 A2 00 34 CC 56 A0 01 A1 02 DD 03 DD 04 DD 05 DD 06 DD 07 DD 08 DD
# ignored target, then frames cut off inside the address
T 4 9F 00 100 CC 100 00 100 00
T 2 A5 00 12 CC
T 1 80 00
T 4 80 00 04 CC 9A AD BC 9A
V 1 0000BC9A
V 3 44332211
V 7 BBAA0000
V 0 00000000
V 5 00000000

//--- all.f
hdl/spi_proto_pkg.sv
hdl/csr_map_pkg.sv
hdl/spi_trx.sv
hdl/csr_regs.sv
hdl/csr_spi.sv
sim/csr_spi_assertions.sv
sim/csr_spi_tb.sv

//--- Bender.yml
package:
  name: csr_spi

sources:
  - hdl/spi_proto_pkg.sv
  - hdl/csr_map_pkg.sv
  - hdl/spi_trx.sv
  - hdl/csr_regs.sv
  - hdl/csr_spi.sv
  - target: simulation
    files:
      - sim/csr_spi_assertions.sv
      - sim/csr_spi_tb.sv
